// ==== design/sprite_dma_defines.svh ====
// sprite DMA board constants
// raster geometry, pixel clock divide and sprite bank count
`ifndef SPRITE_DMA_DEFINES_SVH
`define SPRITE_DMA_DEFINES_SVH

`define PXL_DIV  2   // clk cycles per pixel enable

// horizontal raster in pixel enables, blank covers the tail of the line
`define H_TOTAL  64
`define H_BLANK  16

// vertical raster in lines, vertical blank sits at the end of the frame
`define V_TOTAL  80
`define V_BLANK  16

`define BANKS    4   // sprite attribute banks filled by one DMA

`endif

// ==== design/video_pkg.sv ====
// raster timing types
// shared by the timing generator, the DMA controller and the bus interface
package video_pkg;

    // phase inside a group of four pixels, the DMA sequences its
    // request, strobe and count steps on it
    typedef logic [1:0] h_phase_t;

    // pixel position inside one line, sized for 64 pixel enables
    typedef logic [5:0] pxl_cnt_t;

    // line position inside one frame, sized for 80 lines
    typedef logic [6:0] line_cnt_t;

    // the low bits of the pixel count double as the phase so the
    // line length must stay a multiple of four

endpackage

// ==== design/dma_pkg.sv ====
// sprite DMA transfer types
// count, main memory bus and the bank readout word
package dma_pkg;

    // transfer count, bit 10 flags the end of the copy,
    // bits 9:8 pick the bank and bits 7:0 the entry inside it
    typedef logic [10:0] dma_cnt_t;

    // main memory address as it leaves the board, with its lines
    // swapped around relative to the count
    typedef logic [9:0] bus_addr_t;

    // one byte from main memory
    typedef logic [7:0] bus_data_t;

    // all four banks read at the same entry
    // bank 0 in bits 7:0, bank 1 in 15:8, bank 2 in 23:16
    // and the narrow bank 3 in 28:24
    typedef logic [28:0] sprite_word_t;

endpackage

// ==== design/dma_bus_if.sv ====
// DMA controller to sprite store link
// carries the transfer count, the copy strobe, the phase and the memory byte
interface dma_bus_if;
    import dma_pkg::*;
    import video_pkg::*;

    dma_cnt_t  cnt;     // bank select and entry for the store
    logic      dma_cs;  // copy in progress, main memory is driving data
    h_phase_t  h;       // write only lands on the odd phases
    bus_data_t data;    // byte fetched from main memory

    // the controller owns every signal of the link
    modport ctrl (
        output cnt,
        output dma_cs,
        output h,
        output data
    );

    // the store only listens
    modport store (
        input  cnt,
        input  dma_cs,
        input  h,
        input  data
    );
endinterface

// ==== design/video_timing.sv ====
// video timing generator
// divides clk to the pixel enable and decodes phase and both blanks
`include "sprite_dma_defines.svh"

module video_timing (
    input  logic                clk,
    input  logic                rst_n,
    output logic                pxl_cen,
    output video_pkg::h_phase_t h,
    output logic                hbd_n,
    output logic                vb
);
    import video_pkg::*;

    localparam int DIV_W = $clog2(`PXL_DIV);

    logic [DIV_W-1:0] div_cnt;   // clk position inside one pixel period
    pxl_cnt_t         pxl_cnt;   // pixel inside the current line
    line_cnt_t        line_cnt;  // line inside the current frame

    // pixel enable fires on the last clk of each divide period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (pxl_cen) begin
            div_cnt <= '0;  // start the next pixel period
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    assign pxl_cen = (div_cnt == DIV_W'(`PXL_DIV - 1));

    // raster counters only move on the pixel enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cnt  <= '0;
            line_cnt <= '0;
        end else if (pxl_cen) begin
            if (pxl_cnt == pxl_cnt_t'(`H_TOTAL - 1)) begin
                pxl_cnt <= '0;
                if (line_cnt == line_cnt_t'(`V_TOTAL - 1)) begin
                    line_cnt <= '0;  // frame wraps
                end else begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end else begin
                pxl_cnt <= pxl_cnt + 1'b1;
            end
        end
    end

    // the phase is just the low two pixel bits so it steps once per enable
    assign h = pxl_cnt[1:0];

    assign hbd_n = (pxl_cnt < pxl_cnt_t'(`H_TOTAL - `H_BLANK));   // low over the last pixels
    assign vb    = (line_cnt >= line_cnt_t'(`V_TOTAL - `V_BLANK)); // high over the last lines

endmodule

// ==== design/dma_ctrl.sv ====
// sprite DMA controller
// takes the CPU bus at vertical blank and walks main memory with a scrambled address
module dma_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pxl_cen,
    input  logic                busak_n,
    input  logic                hbd_n,
    input  logic                vb,
    input  video_pkg::h_phase_t h,
    input  dma_pkg::bus_data_t  bus_data,
    output logic                busrq_n,
    output logic                dma_cs,
    output logic                dm10,
    output dma_pkg::bus_addr_t  bus_addr,
    dma_bus_if.ctrl             bus
);
    import dma_pkg::*;

    dma_cnt_t cnt;       // transfer count, also sweeps the banks outside a DMA
    logic     vb_l;      // vertical blank one clk ago
    logic     vb_rise;
    logic     clr;       // count clear flag, sampled on phase 3
    logic     clr_l;     // clear flag from the previous phase 3
    logic     clr_rise;

    assign vb_rise  = vb && !vb_l;
    assign clr_rise = clr && !clr_l;
    assign dm10     = cnt[10];  // the copy has covered all four banks

    // bus request drops at the start of vertical blank and comes back
    // once the count runs past the last entry of bank 3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vb_l    <= 1'b0;
            busrq_n <= 1'b1;
        end else begin
            vb_l <= vb;
            if (vb_rise) begin
                busrq_n <= 1'b0;
            end
            if (cnt[10]) begin
                busrq_n <= 1'b1;  // done wins over a new request
            end
        end
    end

    // everything else runs at pixel rate, sequenced by the phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dma_cs <= 1'b0;
            clr    <= 1'b0;
            clr_l  <= 1'b0;
            cnt    <= '0;
        end else if (pxl_cen) begin
            if (h == 2'd1) begin
                dma_cs <= !busak_n;  // grant turns into the memory strobe
            end
            if (h == 2'd3) begin
                clr_l <= clr;
                // while waiting on the grant the flag stays low, so the
                // grant itself makes the clear edge that restarts the count
                clr   <= (!dma_cs && !busrq_n) ? 1'b0 : (!hbd_n || dma_cs);
            end
            if (clr_rise) begin
                cnt <= '0;
            end else if (!h[0] && (h[1] || busak_n)) begin
                // two steps per four pixels normally, one step during a grant
                cnt <= cnt + 1'b1;
            end
        end
    end

    // address lines are wired out of order on the board
    always_comb begin
        bus_addr[2] = cnt[0];
        bus_addr[6] = cnt[1];
        bus_addr[3] = cnt[2];
        bus_addr[4] = cnt[3];
        bus_addr[7] = cnt[4];
        bus_addr[8] = cnt[5];
        bus_addr[9] = cnt[6];
        bus_addr[5] = cnt[7];
        bus_addr[0] = cnt[8];
        bus_addr[1] = cnt[9];
    end

    // hand the count, strobe, phase and fetched byte to the store
    assign bus.cnt    = cnt;
    assign bus.dma_cs = dma_cs;
    assign bus.h      = h;
    assign bus.data   = bus_data;

endmodule

// ==== design/sprite_store.sv ====
// sprite attribute store
// four banks of 256 entries written by the DMA and read back on every pixel enable
`include "sprite_dma_defines.svh"

module sprite_store (
    input  logic                 clk,
    input  logic                 pxl_cen,
    dma_bus_if.store             bus,
    output dma_pkg::sprite_word_t sprite_word
);
    import dma_pkg::*;

    localparam int BYTE_W = $bits(bus_data_t);
    localparam int ENTRIES = 256;

    logic [7:0] entry;  // same entry in every bank
    logic [1:0] bank;   // bank the current byte belongs to
    logic       wr_ph;  // odd phase, memory data is stable here

    assign entry = bus.cnt[7:0];
    assign bank  = bus.cnt[9:8];
    assign wr_ph = bus.h[0];

    for (genvar b = 0; b < `BANKS; b++) begin : g_bank
        // the top bank takes whatever width is left in the sprite word
        localparam int LO = b * BYTE_W;
        localparam int W  = (b == `BANKS - 1) ? $bits(sprite_word_t) - LO : BYTE_W;

        logic [W-1:0] mem [0:ENTRIES-1];
        logic [W-1:0] q;   // registered readout of this bank
        logic         we;

        // only one bank strobes at a time, picked by count bits 9:8
        assign we = bus.dma_cs && wr_ph && (bank == 2'(b));

        always_ff @(posedge clk) begin
            if (pxl_cen) begin
                if (we) begin
                    mem[entry] <= bus.data[W-1:0];  // narrow bank drops the high bits
                end
                q <= mem[entry];  // old contents come out on a write
            end
        end

        assign sprite_word[LO +: W] = q;
    end

endmodule

// ==== design/sprite_dma_top.sv ====
// sprite DMA subsystem top level
// joins video timing, the DMA controller and the sprite store
module sprite_dma_top (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  pxl_cen,
    output video_pkg::h_phase_t   h,
    output logic                  hbd_n,
    output logic                  vb,
    output logic                  busrq_n,
    input  logic                  busak_n,
    output logic                  dma_cs,
    output dma_pkg::bus_addr_t    bus_addr,
    input  dma_pkg::bus_data_t    bus_data,
    output logic                  dm10,
    output dma_pkg::sprite_word_t sprite_word
);

    // controller to store link
    dma_bus_if dma_bus_inst ();

    // raster timing also drives the board outputs directly
    video_timing video_timing_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .h       (h),
        .hbd_n   (hbd_n),
        .vb      (vb)
    );

    dma_ctrl dma_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .busak_n  (busak_n),
        .hbd_n    (hbd_n),
        .vb       (vb),
        .h        (h),
        .bus_data (bus_data),
        .busrq_n  (busrq_n),
        .dma_cs   (dma_cs),
        .dm10     (dm10),
        .bus_addr (bus_addr),
        .bus      (dma_bus_inst.ctrl)
    );

    // store has no reset, its banks hold whatever the last DMA left
    sprite_store sprite_store_inst (
        .clk         (clk),
        .pxl_cen     (pxl_cen),
        .bus         (dma_bus_inst.store),
        .sprite_word (sprite_word)
    );

endmodule

// ==== test/tb_sprite_dma.sv ====
// sprite DMA testbench
// models main memory and the bus grant, checks the DMA and the bank readout
`include "sprite_dma_defines.svh"

module tb_sprite_dma;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;
    import video_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int FRAME_CLKS   = `H_TOTAL * `V_TOTAL * `PXL_DIV;
    localparam int RUN_CLKS     = 2 * FRAME_CLKS;  // two full frames after reset
    localparam int TIMEOUT_CLKS = 3 * FRAME_CLKS;
    localparam int DMA_STEPS    = 1024;            // one step per entry of all four banks

    logic         clk;
    logic         rst_n;
    logic         pxl_cen;
    h_phase_t     h;
    logic         hbd_n;
    logic         vb;
    logic         busrq_n;
    logic         busak_n;
    logic         dma_cs;
    bus_addr_t    bus_addr;
    bus_data_t    bus_data;
    logic         dm10;
    sprite_word_t sprite_word;

    int           cycle_cnt;
    int           pxl_pos;      // pixel enables since the start of the line
    int           line_pos;     // lines since the start of the frame
    logic         pxl_cen_l;    // pixel enable one clk ago
    logic [3:0]   raster_exp;   // phase, hbd_n and vb the raster must show
    logic         busak_l;      // grant as seen on the last phase 1
    dma_cnt_t     step_now;     // count recovered from the address lines
    dma_cnt_t     step_prev;    // count at the previous phase 2 of this DMA
    logic         step_run;     // a DMA count has started from zero
    int           step_cnt;
    logic         dm10_l;
    int           dma_done_cnt;
    logic         loaded;       // the banks hold a complete copy
    logic         read_valid;
    logic [7:0]   read_entry;   // entry the store registered one enable ago
    sprite_word_t word_exp;
    int           read_checks;

    sprite_dma_top sprite_dma_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // count bit i leaves the board on this address line
    function automatic int addr_bit(input int cnt_bit);
        case (cnt_bit)
            0: return 2;
            1: return 6;
            2: return 3;
            3: return 4;
            4: return 7;
            5: return 8;
            6: return 9;
            7: return 5;
            8: return 0;
            default: return 1;
        endcase
    endfunction

    function automatic bus_addr_t scramble(input logic [9:0] c);
        bus_addr_t a;
        a = '0;
        for (int i = 0; i < 10; i++) begin
            a[addr_bit(i)] = c[i];
        end
        return a;
    endfunction

    function automatic logic [9:0] descramble(input bus_addr_t a);
        logic [9:0] c;
        for (int i = 0; i < 10; i++) begin
            c[i] = a[addr_bit(i)];
        end
        return c;
    endfunction

    // main memory holds a byte that follows its own address
    function automatic bus_data_t mem_byte(input bus_addr_t a);
        return a[7:0] + 8'h5A;
    endfunction

    function automatic sprite_word_t expected_word(input logic [7:0] entry);
        sprite_word_t w;
        bus_data_t    d;
        w = '0;
        for (int b = 0; b < `BANKS; b++) begin
            d = mem_byte(scramble({2'(b), entry}));
            if (b == `BANKS - 1) begin
                w[28:24] = d[4:0];  // narrow bank keeps five bits
            end else begin
                w[b*8 +: 8] = d;
            end
        end
        return w;
    endfunction

    task automatic end_in_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
        end_in_failure();
    endtask

    task automatic abort_with_reason(input string reason);
        $display("%s", reason);
        end_in_failure();
    endtask

    assign step_now   = {dm10, descramble(bus_addr)};
    assign word_exp   = expected_word(read_entry);
    assign raster_exp = {2'(pxl_pos), (pxl_pos < `H_TOTAL - `H_BLANK),
                         (line_pos >= `V_TOTAL - `V_BLANK)};

    // memory answers with the byte of the address seen one clk ago
    always @(posedge clk) begin
        bus_data <= mem_byte(bus_addr);
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CLKS) begin
            abort_with_reason($sformatf("timeout after %0d clk cycles", cycle_cnt));
        end
    end

    // trackers that feed the assertions
    always @(posedge clk) begin
        if (rst_n) begin
            pxl_cen_l <= pxl_cen;
        end
        if (pxl_cen) begin
            if (pxl_pos == `H_TOTAL - 1) begin
                pxl_pos  <= 0;
                line_pos <= (line_pos == `V_TOTAL - 1) ? 0 : line_pos + 1;
            end else begin
                pxl_pos <= pxl_pos + 1;
            end
        end
        if (pxl_cen && h == 2'd1) begin
            busak_l <= busak_n;
        end
        if (pxl_cen && h == 2'd2) begin
            if (!dma_cs) begin
                step_run <= 1'b0;  // strobe gone, the copy is over
            end else if (step_now == '0 && (!step_run || step_prev == '0)) begin
                // the clear holds the count at zero for a whole phase cycle
                step_run  <= 1'b1;
                step_prev <= '0;
                step_cnt  <= 1;
            end else if (step_run) begin
                step_prev <= step_now;
                step_cnt  <= step_cnt + 1;
            end
        end
        dm10_l <= dm10;
        if (dm10 && !dm10_l) begin
            dma_done_cnt <= dma_done_cnt + 1;
            loaded       <= 1'b1;
        end
        if (pxl_cen) begin
            read_entry <= step_now[7:0];
            read_valid <= loaded;
            if (read_valid) begin
                read_checks <= read_checks + 1;
            end
        end
    end

    reset_state: assert property (@(posedge clk) $rose(rst_n) |-> busrq_n && !dma_cs)
        else report_mismatch("reset_state", 32'b10, 32'({$sampled(busrq_n), $sampled(dma_cs)}));

    pixel_enable: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen == !pxl_cen_l)
        else report_mismatch("pixel_enable", 32'(!$sampled(pxl_cen_l)),
                             32'($sampled(pxl_cen)));

    raster_timing: assert property (@(posedge clk) disable iff (!rst_n)
        {h, hbd_n, vb} == raster_exp)
        else report_mismatch("raster_timing", 32'($sampled(raster_exp)),
                             32'({$sampled(h), $sampled(hbd_n), $sampled(vb)}));

    vb_request: assert property (@(posedge clk) disable iff (!rst_n) $rose(vb) |=> !busrq_n)
        else report_mismatch("vb_request", 32'd0, 32'($sampled(busrq_n)));

    done_release: assert property (@(posedge clk) disable iff (!rst_n) $rose(dm10) |=> busrq_n)
        else report_mismatch("done_release", 32'd1, 32'($sampled(busrq_n)));

    grant_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && h == 2'd1 |=> dma_cs == !busak_l)
        else report_mismatch("grant_strobe", 32'(!$sampled(busak_l)), 32'($sampled(dma_cs)));

    addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && h == 2'd2 && dma_cs && step_run && (step_now != '0 || step_prev != '0)
        |-> step_now == dma_cnt_t'(step_prev + 1))
        else report_mismatch("addr_step", 32'($sampled(step_prev) + 1), 32'($sampled(step_now)));

    dma_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dm10) |-> step_cnt == DMA_STEPS)
        else report_mismatch("dma_length", DMA_STEPS, 32'($sampled(step_cnt)));

    sprite_readout: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && read_valid |-> sprite_word == word_exp)
        else report_mismatch("sprite_readout", 32'($sampled(word_exp)),
                             32'($sampled(sprite_word)));

    // bus grant comes back a random number of clks after the request
    initial begin
        int delay;
        forever begin
            @(posedge clk);
            if (!busrq_n && busak_n) begin
                delay = $urandom_range(20, 1);
                repeat (delay - 1) @(posedge clk);
                busak_n <= 1'b0;
                do @(posedge clk); while (!busrq_n);
                busak_n <= 1'b1;  // request withdrawn, give the bus back
            end
        end
    end

    initial begin
        void'($urandom(73));
        clk          = 1'b0;
        rst_n        = 1'b0;
        busak_n      = 1'b1;
        bus_data     = '0;
        cycle_cnt    = 0;
        pxl_pos      = 0;
        line_pos     = 0;
        pxl_cen_l    = 1'b1;
        busak_l      = 1'b1;
        step_prev    = '0;
        step_run     = 1'b0;
        step_cnt     = 0;
        dm10_l       = 1'b0;
        dma_done_cnt = 0;
        loaded       = 1'b0;
        read_valid   = 1'b0;
        read_entry   = '0;
        read_checks  = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (RUN_CLKS) @(posedge clk);
        if (dma_done_cnt == 0 || read_checks == 0) begin
            abort_with_reason("the run ended before a full DMA and its readout were checked");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+design
design/video_pkg.sv
design/dma_pkg.sv
design/dma_bus_if.sv
design/video_timing.sv
design/dma_ctrl.sv
design/sprite_store.sv
design/sprite_dma_top.sv
test/tb_sprite_dma.sv

// ==== run.sh ====
#!/bin/sh
# compile the sprite DMA testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    -f sources.f --top-module tb_sprite_dma -o sim_tb_sprite_dma

./obj_dir/sim_tb_sprite_dma
